/* hw/raster_pkg.sv */
package raster_pkg;

    // ==================================================
    // Datapath widths
    // ==================================================
    localparam int vert_w   = 16;   // Vertex value
    localparam int chan_w   = 8;    // Color channel
    localparam int delta_w  = 17;   // Vertex delta, signed
    localparam int coef_w   = 11;   // Edge A/B coefficient, signed
    localparam int raw_w    = 29;   // Sum of two delta x coefficient products
    localparam int inv_w    = 16;   // Reciprocal area, UQ0.16
    localparam int shift_w  = 4;    // Area shift count
    localparam int scaled_w = 45;   // Raw sum x reciprocal area
    localparam int coord_w  = 10;   // Screen coordinate
    localparam int offs_w   = 11;   // Bbox offset from vertex 0, signed
    localparam int frac_w   = 16;   // Fraction bits of 16.16 results
    localparam int out_w    = 32;   // Result word
    localparam int kind_w   = 2;    // Attribute kind code

    // Packed request beat between skid buffer stages
    localparam int req_beat_w = kind_w + 2 * delta_w + vert_w + 4 * coef_w
                              + inv_w + shift_w + 2 * offs_w;

    // ==================================================
    // Attribute kinds
    // ==================================================
    localparam logic [kind_w-1:0] kind_color    = 2'd0;  // 8-bit unsigned channel
    localparam logic [kind_w-1:0] kind_unsigned = 2'd1;  // Depth or Q
    localparam logic [kind_w-1:0] kind_signed   = 2'd2;  // Texture coordinate

    // Vertex word as seen by the decoder
    // chan[1] is padding, chan[0] holds the color value
    typedef union packed {
        logic [vert_w-1:0]            wide;  // Depth, Q or texture coordinate
        logic [1:0][chan_w-1:0]       chan;  // Color channel in the low byte
    } vert_word_u;

endpackage

/* hw/raster_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Decoded attribute request, ingress to pipeline
interface deriv_req_if
    import raster_pkg::*;
();
    logic                        valid;
    logic                        ready;
    logic [kind_w-1:0]           kind;
    logic signed [delta_w-1:0]   d10;       // v1 - v0
    logic signed [delta_w-1:0]   d20;       // v2 - v0
    logic [vert_w-1:0]           base;      // Vertex 0 value, decoded
    logic signed [coef_w-1:0]    e1a;
    logic signed [coef_w-1:0]    e1b;
    logic signed [coef_w-1:0]    e2a;
    logic signed [coef_w-1:0]    e2b;
    logic [inv_w-1:0]            inv_area;
    logic [shift_w-1:0]          shift;
    logic signed [offs_w-1:0]    sx;        // Bbox origin minus x0
    logic signed [offs_w-1:0]    sy;        // Bbox origin minus y0

    modport source (
        output valid, kind, d10, d20, base, e1a, e1b, e2a, e2b, inv_area, shift, sx, sy,
        input  ready
    );

    modport sink (
        input  valid, kind, d10, d20, base, e1a, e1b, e2a, e2b, inv_area, shift, sx, sy,
        output ready
    );
endinterface

// Finished derivative triple, pipeline to output queue
interface deriv_res_if
    import raster_pkg::*;
();
    logic                        valid;
    logic                        ready;
    logic [kind_w-1:0]           kind;
    logic signed [out_w-1:0]     dx;        // 16.16
    logic signed [out_w-1:0]     dy;        // 16.16
    logic signed [out_w-1:0]     init;      // Value at bbox origin

    modport source (
        output valid, kind, dx, dy, init,
        input  ready
    );

    modport sink (
        input  valid, kind, dx, dy, init,
        output ready
    );
endinterface

`default_nettype wire

/* hw/attr_ingress.sv */
`timescale 1ns/1ps
`default_nettype none

module attr_ingress
    import raster_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [kind_w-1:0]          in_kind,
    input  logic [vert_w-1:0]          in_v0,
    input  logic [vert_w-1:0]          in_v1,
    input  logic [vert_w-1:0]          in_v2,
    input  logic signed [coef_w-1:0]   edge1_a,
    input  logic signed [coef_w-1:0]   edge1_b,
    input  logic signed [coef_w-1:0]   edge2_a,
    input  logic signed [coef_w-1:0]   edge2_b,
    input  logic [inv_w-1:0]           inv_area,
    input  logic [shift_w-1:0]         area_shift,
    input  logic [coord_w-1:0]         bbox_min_x,
    input  logic [coord_w-1:0]         bbox_min_y,
    input  logic [coord_w-1:0]         x0,
    input  logic [coord_w-1:0]         y0,
    deriv_req_if.source                req
);

    // Extend one vertex word to a signed delta operand
    function automatic logic signed [delta_w-1:0] widen(input logic [kind_w-1:0] k,
                                                        input vert_word_u w);
        logic signed [delta_w-1:0] r;
        case (k)
            kind_color:  r = {{(delta_w - chan_w){1'b0}}, w.chan[0]};  // Zero extend byte
            kind_signed: r = {w.wide[vert_w-1], w.wide};               // Sign extend
            default:     r = {1'b0, w.wide};                           // Depth or Q
        endcase
        return r;
    endfunction

    vert_word_u                  w0, w1, w2;
    logic signed [delta_w-1:0]   e0, e1, e2;       // Extended vertex values
    logic [vert_w-1:0]           base_c;
    logic signed [offs_w-1:0]    sx_c, sy_c;
    logic [req_beat_w-1:0]       dec_beat;         // Decoded input beat
    logic [req_beat_w-1:0]       main_beat, skid_beat;
    logic                        main_valid, skid_valid;
    logic                        in_fire, load_main;

    // ==================================================
    // Decode
    // ==================================================
    assign w0 = in_v0;
    assign w1 = in_v1;
    assign w2 = in_v2;
    assign e0 = widen(in_kind, w0);
    assign e1 = widen(in_kind, w1);
    assign e2 = widen(in_kind, w2);

    // Base keeps only the channel byte for colors
    assign base_c = (in_kind == kind_color) ? {{(vert_w - chan_w){1'b0}}, w0.chan[0]} : w0.wide;

    // Bbox origin relative to vertex 0
    assign sx_c = $signed({1'b0, bbox_min_x}) - $signed({1'b0, x0});
    assign sy_c = $signed({1'b0, bbox_min_y}) - $signed({1'b0, y0});

    assign dec_beat = {in_kind, e1 - e0, e2 - e0, base_c, edge1_a, edge1_b, edge2_a, edge2_b,
                       inv_area, area_shift, sx_c, sy_c};

    // ==================================================
    // Two-entry skid buffer
    // ==================================================
    assign in_ready  = ~skid_valid;                 // Straight from a flop
    assign in_fire   = in_valid & in_ready;
    assign load_main = ~main_valid | req.ready;     // Main slot free or draining

    always_ff @(posedge clk) begin
        if (reset) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_main) begin
            main_valid <= skid_valid | in_fire;     // Skid drains first
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;                     // Park beat while stalled
        end
    end

    always_ff @(posedge clk) begin
        if (load_main)
            main_beat <= skid_valid ? skid_beat : dec_beat;
        if (~load_main & in_fire)
            skid_beat <= dec_beat;
    end

    assign req.valid = main_valid;
    assign {req.kind, req.d10, req.d20, req.base, req.e1a, req.e1b, req.e2a, req.e2b,
            req.inv_area, req.shift, req.sx, req.sy} = main_beat;

endmodule

`default_nettype wire

/* hw/deriv_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module deriv_pipe
    import raster_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    deriv_req_if.sink     req,
    deriv_res_if.source   res
);

    logic                        adv;       // Whole pipe moves together

    // Stage one registers
    logic                        s1_valid;
    logic [kind_w-1:0]           s1_kind;
    logic signed [raw_w-1:0]     s1_raw_dx, s1_raw_dy;
    logic [vert_w-1:0]           s1_base;
    logic [inv_w-1:0]            s1_inv;
    logic [shift_w-1:0]          s1_shift;
    logic signed [offs_w-1:0]    s1_sx, s1_sy;

    // Stage two registers
    logic                        s2_valid;
    logic [kind_w-1:0]           s2_kind;
    logic signed [out_w-1:0]     s2_dx, s2_dy;
    logic [vert_w-1:0]           s2_base;
    logic signed [offs_w-1:0]    s2_sx, s2_sy;

    // Stage three registers
    logic                        s3_valid;
    logic [kind_w-1:0]           s3_kind;
    logic signed [out_w-1:0]     s3_dx, s3_dy, s3_init;

    // Combinational stage results
    logic signed [raw_w-1:0]     raw_dx, raw_dy;
    logic signed [scaled_w-1:0]  scl_dx, scl_dy;
    logic signed [out_w-1:0]     init_c;

    // ==================================================
    // Flow control
    // ==================================================
    assign adv       = res.ready | ~s3_valid;   // Last stage empty or leaving
    assign req.ready = adv;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else if (adv) begin
            s1_valid <= req.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // ==================================================
    // Stage one: edge products
    // ==================================================
    // 17b delta x 11b coef, summed in 29 bits
    assign raw_dx = req.d10 * req.e1a + req.d20 * req.e2a;
    assign raw_dy = req.d10 * req.e1b + req.d20 * req.e2b;

    always_ff @(posedge clk) begin
        if (adv) begin
            s1_kind   <= req.kind;
            s1_raw_dx <= raw_dx;
            s1_raw_dy <= raw_dy;
            s1_base   <= req.base;
            s1_inv    <= req.inv_area;
            s1_shift  <= req.shift;
            s1_sx     <= req.sx;
            s1_sy     <= req.sy;
        end
    end

    // ==================================================
    // Stage two: area scaling
    // ==================================================
    // inv_area is unsigned, so one zero bit in front before the signed multiply
    assign scl_dx = s1_raw_dx * $signed({1'b0, s1_inv});
    assign scl_dy = s1_raw_dy * $signed({1'b0, s1_inv});

    always_ff @(posedge clk) begin
        if (adv) begin
            s2_kind <= s1_kind;
            s2_dx   <= out_w'(scl_dx >>> s1_shift);  // Arithmetic shift, keep low 32
            s2_dy   <= out_w'(scl_dy >>> s1_shift);
            s2_base <= s1_base;
            s2_sx   <= s1_sx;
            s2_sy   <= s1_sy;
        end
    end

    // ==================================================
    // Stage three: initial value at bbox origin
    // ==================================================
    // Base lands on the integer part of 16.16, products wrap at 32 bits
    assign init_c = $signed({s2_base, {frac_w{1'b0}}}) + s2_dx * s2_sx + s2_dy * s2_sy;

    always_ff @(posedge clk) begin
        if (adv) begin
            s3_kind <= s2_kind;
            s3_dx   <= s2_dx;
            s3_dy   <= s2_dy;
            s3_init <= init_c;
        end
    end

    assign res.valid = s3_valid;
    assign res.kind  = s3_kind;
    assign res.dx    = s3_dx;
    assign res.dy    = s3_dy;
    assign res.init  = s3_init;

endmodule

`default_nettype wire

/* hw/result_egress.sv */
`timescale 1ns/1ps
`default_nettype none

module result_egress
    import raster_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    deriv_res_if.sink                res,
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [kind_w-1:0]        out_kind,
    output logic signed [out_w-1:0]  out_dx,
    output logic signed [out_w-1:0]  out_dy,
    output logic signed [out_w-1:0]  out_init
);

    // Two-slot storage, no reset on payload
    logic [kind_w-1:0]        q_kind [2];
    logic signed [out_w-1:0]  q_dx   [2];
    logic signed [out_w-1:0]  q_dy   [2];
    logic signed [out_w-1:0]  q_init [2];

    logic        wr_ptr, rd_ptr;    // One bit each for two entries
    logic [1:0]  count;             // 0 to 2
    logic        push, pop;

    // ==================================================
    // Queue control
    // ==================================================
    assign res.ready = (count != 2'd2);     // Room for one more
    assign out_valid = (count != 2'd0);
    assign push      = res.valid & res.ready;
    assign pop       = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
            count <= count + {1'b0, push} - {1'b0, pop};    // Net occupancy change
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            q_kind[wr_ptr] <= res.kind;
            q_dx[wr_ptr]   <= res.dx;
            q_dy[wr_ptr]   <= res.dy;
            q_init[wr_ptr] <= res.init;
        end
    end

    // Head of queue
    assign out_kind = q_kind[rd_ptr];
    assign out_dx   = q_dx[rd_ptr];
    assign out_dy   = q_dy[rd_ptr];
    assign out_init = q_init[rd_ptr];

endmodule

`default_nettype wire

/* hw/raster_deriv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module raster_deriv_top
    import raster_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,

    // Attribute beat in
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [kind_w-1:0]        in_kind,
    input  logic [vert_w-1:0]        in_v0,
    input  logic [vert_w-1:0]        in_v1,
    input  logic [vert_w-1:0]        in_v2,
    input  logic signed [coef_w-1:0] edge1_a,
    input  logic signed [coef_w-1:0] edge1_b,
    input  logic signed [coef_w-1:0] edge2_a,
    input  logic signed [coef_w-1:0] edge2_b,
    input  logic [inv_w-1:0]         inv_area,      // UQ0.16
    input  logic [shift_w-1:0]       area_shift,
    input  logic [coord_w-1:0]       bbox_min_x,
    input  logic [coord_w-1:0]       bbox_min_y,
    input  logic [coord_w-1:0]       x0,
    input  logic [coord_w-1:0]       y0,

    // Result out
    output logic                     out_valid,
    input  logic                     out_ready,
    output logic [kind_w-1:0]        out_kind,
    output logic signed [out_w-1:0]  out_dx,
    output logic signed [out_w-1:0]  out_dy,
    output logic signed [out_w-1:0]  out_init
);

    deriv_req_if req_if ();
    deriv_res_if res_if ();

    // ==================================================
    // Input side
    // ==================================================
    attr_ingress attr_ingress_inst (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_kind    (in_kind),
        .in_v0      (in_v0),
        .in_v1      (in_v1),
        .in_v2      (in_v2),
        .edge1_a    (edge1_a),
        .edge1_b    (edge1_b),
        .edge2_a    (edge2_a),
        .edge2_b    (edge2_b),
        .inv_area   (inv_area),
        .area_shift (area_shift),
        .bbox_min_x (bbox_min_x),
        .bbox_min_y (bbox_min_y),
        .x0         (x0),
        .y0         (y0),
        .req        (req_if)
    );

    // Derivative arithmetic
    deriv_pipe deriv_pipe_inst (
        .clk   (clk),
        .reset (reset),
        .req   (req_if),
        .res   (res_if)
    );

    // ==================================================
    // Output side
    // ==================================================
    result_egress result_egress_inst (
        .clk       (clk),
        .reset     (reset),
        .res       (res_if),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_kind  (out_kind),
        .out_dx    (out_dx),
        .out_dy    (out_dy),
        .out_init  (out_init)
    );

endmodule

`default_nettype wire

/* verif/raster_deriv_asserts.sv */
`timescale 1ns/1ps

module raster_deriv_asserts
    import raster_pkg::*;
(
    input logic                                                     clk,
    input logic                                                     reset,
    input logic                                                     in_valid,
    input logic                                                     in_ready,
    input logic [kind_w+3*vert_w+4*coef_w+inv_w+shift_w+4*coord_w-1:0] in_data,
    input logic                                                     out_valid,
    input logic                                                     out_ready,
    input logic [kind_w+3*out_w-1:0]                                out_data
);

    int unsigned fail_count = 0;    // Read by the testbench summary

    // Result stays put while the consumer stalls
    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin
            fail_count++;
            $error("out_valid or result data changed before the result was taken");
        end

    // Same rule on the input side
    a_in_hold: assert property (@(posedge clk) disable iff (reset)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else begin
            fail_count++;
            $error("in_valid or beat data changed before the beat was taken");
        end

    a_reset_idle: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high right after reset");
        end

endmodule

bind raster_deriv_top raster_deriv_asserts raster_deriv_asserts_inst (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   ({in_kind, in_v0, in_v1, in_v2, edge1_a, edge1_b, edge2_a, edge2_b,
                 inv_area, area_shift, bbox_min_x, bbox_min_y, x0, y0}),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  ({out_kind, out_dx, out_dy, out_init})
);

/* verif/tb_raster_deriv.sv */
`timescale 1ns/1ps

module tb_raster_deriv
    import raster_pkg::*;
();

    localparam int max_cycles = 16 + 400 * 30;  // Reset plus 30 cycles per beat

    logic clk, reset, in_valid, in_ready, out_valid, out_ready, bp_mode;
    logic [kind_w-1:0]        in_kind, out_kind;
    logic [vert_w-1:0]        in_v0, in_v1, in_v2;
    logic signed [coef_w-1:0] edge1_a, edge1_b, edge2_a, edge2_b;
    logic [inv_w-1:0]         inv_area;
    logic [shift_w-1:0]       area_shift;
    logic [coord_w-1:0]       bbox_min_x, bbox_min_y, x0, y0;
    logic signed [out_w-1:0]  out_dx, out_dy, out_init;

    // Expected results in acceptance order
    logic [kind_w-1:0] exp_kind [$];
    logic [out_w-1:0]  exp_dx [$], exp_dy [$], exp_init [$];
    string             exp_name [$];
    int                value_errors, other_errors, cycles;

    raster_deriv_top raster_deriv_top_inst (.*);

    // ==================================================
    // Clock, timeout, consumer
    // ==================================================
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d results still missing", cycles,
                 exp_dx.size());
        $display("test failed");
        $finish;
    end

    initial begin
        forever begin
            @(posedge clk);
            #1 out_ready = bp_mode ? 1'($urandom % 2) : 1'b1;  // Half-rate stalls
        end
    end

    // ==================================================
    // Reference model
    // ==================================================
    function automatic longint ext_val(input logic [kind_w-1:0] k, input logic [vert_w-1:0] v);
        if (k == kind_color)
            return longint'(v[chan_w-1:0]);     // Low byte only
        else if (k == kind_signed)
            return longint'($signed(v));
        return longint'(v);
    endfunction

    task automatic model_push(input string name);
        longint e0, e1, e2, rdx, rdy, sdx, sdy, sx, sy, init_v;
        logic [out_w-1:0] dx32, dy32;
        e0  = ext_val(in_kind, in_v0);
        e1  = ext_val(in_kind, in_v1);
        e2  = ext_val(in_kind, in_v2);
        rdx = (e1 - e0) * longint'(edge1_a) + (e2 - e0) * longint'(edge2_a);
        rdy = (e1 - e0) * longint'(edge1_b) + (e2 - e0) * longint'(edge2_b);
        sdx = (rdx * longint'(inv_area)) >>> area_shift;
        sdy = (rdy * longint'(inv_area)) >>> area_shift;
        dx32 = sdx[out_w-1:0];                  // Truncate to 16.16
        dy32 = sdy[out_w-1:0];
        sx  = longint'(bbox_min_x) - longint'(x0);
        sy  = longint'(bbox_min_y) - longint'(y0);
        init_v = (e0 <<< frac_w) + longint'($signed(dx32)) * sx + longint'($signed(dy32)) * sy;
        exp_kind.push_back(in_kind);
        exp_dx.push_back(dx32);
        exp_dy.push_back(dy32);
        exp_init.push_back(init_v[out_w-1:0]);
        exp_name.push_back(name);
    endtask

    // ==================================================
    // Stimulus
    // ==================================================
    task automatic make_beat(input int mode);
        in_kind    = kind_color;
        in_v0      = 16'($urandom);             // Upper byte is padding for colors
        in_v1      = 16'($urandom);
        in_v2      = 16'($urandom);
        edge1_a    = 11'($urandom);
        edge1_b    = 11'($urandom);
        edge2_a    = 11'($urandom);
        edge2_b    = 11'($urandom);
        inv_area   = 16'($urandom);
        area_shift = 4'($urandom);
        bbox_min_x = 10'($urandom);
        bbox_min_y = 10'($urandom);
        x0         = 10'($urandom);
        y0         = 10'($urandom);
        case (mode)
            1: begin
                in_kind    = kind_unsigned;
                in_v0      = 16'hffff - 16'($urandom % 256);
                in_v1      = 16'hffff - 16'($urandom % 256);
                in_v2      = 16'($urandom % 4096);  // Large negative delta
                area_shift = 4'($urandom % 3);
            end
            2: begin
                in_kind    = kind_signed;
                in_v0      = {1'b1, 15'($urandom)};
                x0         = 10'(512 + $urandom % 512);
                y0         = 10'(512 + $urandom % 512);
                bbox_min_x = x0 - 10'(1 + $urandom % 511);  // Origin left of vertex 0
                bbox_min_y = y0 - 10'(1 + $urandom % 511);
            end
            3: in_kind = 2'($urandom % 3);
            4: begin
                in_kind = 2'($urandom % 3);
                case ($urandom % 3)
                    0:       inv_area = '0;
                    1:       area_shift = 4'd0;
                    default: area_shift = 4'd15;
                endcase
            end
            default: ;
        endcase
    endtask

    // Holds the beat until in_ready is seen high before an edge
    task automatic send_beat(input string name);
        logic taken;
        in_valid = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
        model_push(name);
        in_valid = 1'b0;
    endtask

    task automatic run_phase(input string name, input int mode, input int count, input bit bp);
        bp_mode = bp;
        repeat (count) begin
            make_beat(mode);
            send_beat(name);
            if ($urandom % 4 == 0) begin
                @(posedge clk);                 // Idle gap
                #1;
            end
        end
    endtask

    // ==================================================
    // Scoreboard
    // ==================================================
    task automatic check_result();
        string name;
        assert (exp_dx.size() != 0) else begin
            other_errors++;
            $display("A result came out with no accepted beat left to match it");
        end
        if (exp_dx.size() != 0) begin
            name = exp_name.pop_front();
            assert (out_kind === exp_kind[0]) else begin
                value_errors++;
                $display("[ERROR] %s kind expected %0d actual %0d", name, exp_kind[0], out_kind);
            end
            assert (out_dx === exp_dx[0]) else begin
                value_errors++;
                $display("[ERROR] %s dx expected %h actual %h", name, exp_dx[0], out_dx);
            end
            assert (out_dy === exp_dy[0]) else begin
                value_errors++;
                $display("[ERROR] %s dy expected %h actual %h", name, exp_dy[0], out_dy);
            end
            assert (out_init === exp_init[0]) else begin
                value_errors++;
                $display("[ERROR] %s init expected %h actual %h", name, exp_init[0], out_init);
            end
            void'(exp_kind.pop_front());
            void'(exp_dx.pop_front());
            void'(exp_dy.pop_front());
            void'(exp_init.pop_front());
        end
    endtask

    always @(negedge clk) begin
        if (!reset && out_valid && out_ready)   // Taken at the next edge
            check_result();
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        void'($urandom(32'hee9756fe));
        value_errors = 0;
        other_errors = 0;
        reset = 1'b1;
        bp_mode = 1'b0;
        out_ready = 1'b1;
        in_valid = 1'b0;
        make_beat(0);                           // Defined values on every input
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        assert (out_valid === 1'b0) else begin
            value_errors++;
            $display("[ERROR] reset_state out_valid expected 0 actual %b", out_valid);
        end
        assert (in_ready === 1'b1) else begin
            value_errors++;
            $display("[ERROR] reset_state in_ready expected 1 actual %b", in_ready);
        end
        @(posedge clk);
        #1;
        run_phase("color", 0, 100, 1'b0);
        run_phase("unsigned_high", 1, 80, 1'b0);
        run_phase("signed_negative", 2, 80, 1'b0);
        run_phase("backpressure", 3, 100, 1'b1);
        run_phase("zero_area_shift", 4, 40, 1'b0);
        while (exp_dx.size() != 0)
            @(posedge clk);                     // Drain until every result is back
        repeat (10) @(posedge clk);
        $display("Errors: %0d value, %0d protocol, %0d assertion", value_errors, other_errors,
                 raster_deriv_top_inst.raster_deriv_asserts_inst.fail_count);
        if (value_errors + other_errors
            + raster_deriv_top_inst.raster_deriv_asserts_inst.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/raster_pkg.sv
hw/raster_if.sv
hw/attr_ingress.sv
hw/deriv_pipe.sv
hw/result_egress.sv
hw/raster_deriv_top.sv
verif/raster_deriv_asserts.sv
verif/tb_raster_deriv.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_raster_deriv
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
